/* files.f */
+incdir+testbench
common/mips_pkg.sv
hdl/mips_decode.sv
alu/mips_alu.sv
alu/mips_hilo_unit.sv
hdl/mips_execute.sv
testbench/tb_mips_execute.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_mips_execute \
    -f files.f -o sim_tb_mips_execute
./obj_dir/sim_tb_mips_execute > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* testbench/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// signed compare from the sign bits, magnitude compare when signs agree
function automatic logic less_signed(input word_t a, input word_t b);
    if (a[31] != b[31]) begin
        return a[31];
    end
    return a < b;
endfunction

// predicts one issued instruction and advances the model hi/lo
function automatic void predict_exec(
    input  word_t   instr,
    input  word_t   op1,
    input  word_t   op2,
    inout  word_t   hi,
    inout  word_t   lo,
    output expect_t e
);
    logic [4:0]  sh;
    word_t       simm;
    word_t       zimm;
    logic [63:0] uprod;
    word_t       mag_a;
    word_t       mag_b;
    word_t       qmag;
    word_t       rmag;

    simm       = {{16{instr[15]}}, instr[15:0]};
    zimm       = {16'h0000, instr[15:0]};
    sh         = instr[10:6];
    uprod      = {32'h0, op1} * {32'h0, op2};
    e          = '0;
    e.instr    = instr;
    e.mem_addr = op1 + simm; // always rs plus offset
    e.dest     = instr[20:16];
    case (instr[31:26])
        OP_SPECIAL: begin
            e.dest  = instr[15:11];
            e.wr_en = 1'b1;
            if (instr[5:0] inside {FN_SLLV, FN_SRLV, FN_SRAV}) begin
                sh = op1[4:0];
            end
            case (instr[5:0])
                FN_SLL, FN_SLLV: e.result = op2 << sh;
                FN_SRL, FN_SRLV: e.result = op2 >> sh;
                FN_SRA, FN_SRAV: e.result = (op2 >> sh) | (op2[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
                FN_MFHI:         e.result = hi;
                FN_MFLO:         e.result = lo;
                FN_ADD, FN_ADDU: e.result = op1 + op2;
                FN_SUB, FN_SUBU: e.result = op1 - op2;
                FN_AND:          e.result = op1 & op2;
                FN_OR:           e.result = op1 | op2;
                FN_XOR:          e.result = op1 ^ op2;
                FN_NOR:          e.result = ~(op1 | op2);
                FN_SLT:          e.result = {31'h0, less_signed(op1, op2)};
                FN_SLTU:         e.result = {31'h0, op1 < op2};
                FN_MULT: begin
                    e.wr_en = 1'b0;
                    // unsigned product corrected for negative operands
                    hi = uprod[63:32] - (op1[31] ? op2 : 32'h0) - (op2[31] ? op1 : 32'h0);
                    lo = uprod[31:0];
                end
                FN_MULTU: begin
                    e.wr_en = 1'b0;
                    hi      = uprod[63:32];
                    lo      = uprod[31:0];
                end
                FN_DIV: begin
                    e.wr_en = 1'b0;
                    if (op2 == 32'h0) begin
                        hi = op1;
                        lo = 32'hFFFF_FFFF;
                    end else begin
                        mag_a = op1[31] ? -op1 : op1;
                        mag_b = op2[31] ? -op2 : op2;
                        qmag  = mag_a / mag_b;
                        rmag  = mag_a % mag_b;
                        lo    = (op1[31] ^ op2[31]) ? -qmag : qmag; // truncates toward zero
                        hi    = op1[31] ? -rmag : rmag;             // sign of the dividend
                    end
                end
                FN_DIVU: begin
                    e.wr_en = 1'b0;
                    hi      = (op2 == 32'h0) ? op1 : op1 % op2;
                    lo      = (op2 == 32'h0) ? 32'hFFFF_FFFF : op1 / op2;
                end
                FN_MTHI: begin
                    e.wr_en = 1'b0;
                    hi      = op1;
                end
                FN_MTLO: begin
                    e.wr_en = 1'b0;
                    lo      = op1;
                end
                default: begin
                    e.wr_en   = 1'b0;
                    e.illegal = 1'b1;
                end
            endcase
        end
        OP_REGIMM: begin
            case (instr[20:16])
                RI_BLTZ, RI_BLTZAL: e.taken = op1[31];
                RI_BGEZ, RI_BGEZAL: e.taken = !op1[31];
                default:            e.illegal = 1'b1;
            endcase
        end
        OP_BEQ:  e.taken = (op1 == op2);
        OP_BNE:  e.taken = (op1 != op2);
        OP_BLEZ: e.taken = ($signed(op1) <= 32'sd0);
        OP_BGTZ: e.taken = ($signed(op1) > 32'sd0);
        OP_LW, OP_SW: e.mem_en = 1'b1;
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            e.wr_en = 1'b1;
            case (instr[31:26])
                OP_SLTI:  e.result = {31'h0, less_signed(op1, simm)};
                OP_SLTIU: e.result = {31'h0, op1 < simm};
                OP_ANDI:  e.result = op1 & zimm;
                OP_ORI:   e.result = op1 | zimm;
                OP_XORI:  e.result = op1 ^ zimm;
                OP_LUI:   e.result = {instr[15:0], 16'h0000};
                default:  e.result = op1 + simm; // addi, addiu
            endcase
        end
        default: e.illegal = 1'b1;
    endcase
endfunction

`endif

/* testbench/tb_mips_execute.sv */
`timescale 1ns/10ps

module tb_mips_execute;
    import mips_pkg::*;

    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 5 / 4 + 500; // 80% issue rate plus slack

    typedef struct packed {
        logic [31:0] idx;
        word_t       instr;
        word_t       result;
        word_t       mem_addr;
        reg_idx_t    dest;
        logic        wr_en;
        logic        mem_en;
        logic        taken;
        logic        illegal;
    } expect_t;

    `include "exec_model.svh"

    localparam logic [5:0] SPECIAL_FUNCTS [24] = '{
        FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_MFHI, FN_MTHI,
        FN_MFLO, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_ADD, FN_ADDU,
        FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU
    };
    localparam logic [5:0] OTHER_OPCODES [14] = '{
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_ADDI, OP_ADDIU, OP_SLTI,
        OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW
    };
    localparam logic [4:0] REGIMM_CODES [4] = '{RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL};
    localparam logic [5:0] BAD_OPCODES [4]  = '{6'd2, 6'd3, 6'd16, 6'd63}; // j, jal, cop0
    localparam logic [5:0] BAD_FUNCTS [4]   = '{6'd1, 6'd5, 6'd12, 6'd63};
    localparam logic [4:0] BAD_RT [4]       = '{5'd2, 5'd8, 5'd18, 5'd31};

    logic     clk = 1'b0;
    logic     arst_n;
    logic     issue;
    word_t    instr;
    word_t    op1;
    word_t    op2;
    word_t    result;
    word_t    mem_addr;
    reg_idx_t dest_reg;
    logic     wr_en;
    logic     mem_en;
    logic     branch_taken;
    logic     illegal;
    logic     done;

    integer   seed = 32'h23223403;
    int       cycle_cnt = 0;
    int       mismatch_cnt = 0;
    int       protocol_cnt = 0;
    int       issued = 0;
    logic     hilo_written = 1'b0; // last issue wrote hi or lo
    word_t    model_hi = '0;
    word_t    model_lo = '0;
    expect_t  exp_q[$];

    always #50 clk = ~clk;

    mips_execute mips_execute_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue        (issue),
        .instr        (instr),
        .op1          (op1),
        .op2          (op2),
        .result       (result),
        .mem_addr     (mem_addr),
        .dest_reg     (dest_reg),
        .wr_en        (wr_en),
        .mem_en       (mem_en),
        .branch_taken (branch_taken),
        .illegal      (illegal),
        .done         (done)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    // about a fifth of operands land on corner values
    function automatic word_t pick_operand();
        word_t v;
        v = $random(seed);
        if (rand_below(5) == 0) begin
            case (rand_below(5))
                0:       v = 32'h0;
                1:       v = 32'h1;
                2:       v = 32'hFFFF_FFFF;
                3:       v = 32'h8000_0000;
                default: v = v | 32'h8000_0000; // any negative
            endcase
        end
        return v;
    endfunction

    function automatic word_t make_instr();
        word_t       w;
        int unsigned kind;
        w = $random(seed);
        if (hilo_written && rand_below(2) == 0) begin
            w[31:26] = OP_SPECIAL; // read back what was just written
            w[5:0]   = (rand_below(2) == 0) ? FN_MFHI : FN_MFLO;
        end else begin
            kind = rand_below(20);
            if (kind == 0) begin
                case (rand_below(3))
                    0: w[31:26] = BAD_OPCODES[2'(rand_below(4))];
                    1: begin
                        w[31:26] = OP_SPECIAL;
                        w[5:0]   = BAD_FUNCTS[2'(rand_below(4))];
                    end
                    default: begin
                        w[31:26] = OP_REGIMM;
                        w[20:16] = BAD_RT[2'(rand_below(4))];
                    end
                endcase
            end else if (kind < 10) begin
                w[31:26] = OP_SPECIAL;
                w[5:0]   = SPECIAL_FUNCTS[5'(rand_below(24))];
            end else if (kind == 10) begin
                w[31:26] = OP_REGIMM;
                w[20:16] = REGIMM_CODES[2'(rand_below(4))];
            end else begin
                w[31:26] = OTHER_OPCODES[4'(rand_below(14))];
            end
        end
        return w;
    endfunction

    task automatic drive_next();
        issue <= (rand_below(5) != 0); // ~80% of cycles
        instr <= make_instr();
        op1   <= pick_operand();
        op2   <= pick_operand();
    endtask

    task automatic check_word(input string name, input word_t exp_val, input word_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp_val, act_val);
            mismatch_cnt++;
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t exp_val,
                                 input reg_idx_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp_val, act_val);
            mismatch_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp_val, act_val);
            mismatch_cnt++;
        end
    endtask

    task automatic check_outputs();
        expect_t e;
        string   tag;
        if (done) begin
            if (exp_q.size() == 0) begin
                $display("done went high with no instruction issued the cycle before");
                protocol_cnt++;
            end else begin
                e   = exp_q.pop_front();
                tag = $sformatf("instr %0d (%h)", e.idx, e.instr);
                check_flag({tag, " wr_en"}, e.wr_en, wr_en);
                check_flag({tag, " mem_en"}, e.mem_en, mem_en);
                check_flag({tag, " branch_taken"}, e.taken, branch_taken);
                check_flag({tag, " illegal"}, e.illegal, illegal);
                check_word({tag, " mem_addr"}, e.mem_addr, mem_addr);
                if (e.wr_en) begin
                    check_word({tag, " result"}, e.result, result);
                    check_reg_idx({tag, " dest_reg"}, e.dest, dest_reg);
                end
            end
        end else if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            $display("instr %0d was issued but done stayed low", e.idx);
            protocol_cnt++;
        end
    endtask

    initial begin
        expect_t e;
        arst_n = 1'b0;
        issue  = 1'b0;
        instr  = '0;
        op1    = '0;
        op2    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_flag("reset done", 1'b0, done);
        check_flag("reset wr_en", 1'b0, wr_en);
        check_flag("reset mem_en", 1'b0, mem_en);
        check_flag("reset branch_taken", 1'b0, branch_taken);
        check_flag("reset illegal", 1'b0, illegal);
        @(posedge clk);
        arst_n <= 1'b1;

        while (issued < NUM_INSTR) begin
            @(posedge clk);
            drive_next();
            @(negedge clk);
            check_outputs(); // result of the previous cycle's issue
            if (issue) begin
                predict_exec(instr, op1, op2, model_hi, model_lo, e);
                e.idx = issued;
                exp_q.push_back(e);
                issued++;
                hilo_written = (instr[31:26] == OP_SPECIAL) && (instr[5:0] inside
                    {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MTHI, FN_MTLO});
            end
        end
        @(posedge clk);
        issue <= 1'b0;
        @(negedge clk);
        check_outputs();

        $display("%0d instructions, %0d mismatches, %0d protocol errors",
                 issued, mismatch_cnt, protocol_cnt);
        if (mismatch_cnt + protocol_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* hdl/mips_execute.sv */
`timescale 1ns/10ps

module mips_execute (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               issue,
    input  mips_pkg::word_t    instr,
    input  mips_pkg::word_t    op1,
    input  mips_pkg::word_t    op2,
    output mips_pkg::word_t    result,
    output mips_pkg::word_t    mem_addr,
    output mips_pkg::reg_idx_t dest_reg,
    output logic               wr_en,
    output logic               mem_en,
    output logic               branch_taken,
    output logic               illegal,
    output logic               done
);
    import mips_pkg::*;

    alu_op_e  alu_op;
    hilo_op_e hilo_op;
    hilo_op_e hilo_op_q;
    logic     use_imm;
    logic     shift_by_reg;
    logic     dec_wr_en;
    logic     is_branch;
    logic     is_mem;
    logic     dec_illegal;
    reg_idx_t dec_dest;
    word_t    hi;
    word_t    lo;
    word_t    alu_result;
    word_t    alu_mem_addr;
    logic     alu_taken;

    mips_decode mips_decode_inst (
        .instr        (instr),
        .alu_op       (alu_op),
        .hilo_op      (hilo_op),
        .use_imm      (use_imm),
        .shift_by_reg (shift_by_reg),
        .dest_reg     (dec_dest),
        .wr_en        (dec_wr_en),
        .is_branch    (is_branch),
        .is_mem       (is_mem),
        .illegal      (dec_illegal)
    );

    mips_alu mips_alu_inst (
        .instr        (instr),
        .op1          (op1),
        .op2          (op2),
        .hi           (hi),
        .lo           (lo),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .shift_by_reg (shift_by_reg),
        .result       (alu_result),
        .mem_addr     (alu_mem_addr),
        .branch_taken (alu_taken)
    );

    assign hilo_op_q = issue ? hilo_op : HILO_NONE; // hi/lo moves only on issue

    mips_hilo_unit mips_hilo_unit_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .hilo_op (hilo_op_q),
        .op1     (op1),
        .op2     (op2),
        .hi      (hi),
        .lo      (lo)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done         <= 1'b0;
            wr_en        <= 1'b0;
            mem_en       <= 1'b0;
            branch_taken <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            done <= issue;
            if (issue) begin
                wr_en        <= dec_wr_en & ~dec_illegal;
                mem_en       <= is_mem & ~dec_illegal;
                branch_taken <= is_branch & alu_taken & ~dec_illegal;
                illegal      <= dec_illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result   <= alu_result;
            mem_addr <= alu_mem_addr;
            dest_reg <= dec_dest;
        end
    end

    // idle cycles leave the architectural hi/lo untouched
    hilo_hold: assert property (
        @(posedge clk) disable iff (!arst_n) !issue |=> $stable({hi, lo})
    ) else $error("execute: hi/lo changed on a cycle without issue");

endmodule

/* alu/mips_hilo_unit.sv */
`timescale 1ns/10ps

module mips_hilo_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::hilo_op_e hilo_op,
    input  mips_pkg::word_t    op1,
    input  mips_pkg::word_t    op2,
    output mips_pkg::word_t    hi,
    output mips_pkg::word_t    lo
);
    import mips_pkg::*;

    logic [2*WORD_W-1:0] prod_s;
    logic [2*WORD_W-1:0] prod_u;
    word_t               divisor;
    word_t               quot_s;
    word_t               rem_s;
    word_t               quot_u;
    word_t               rem_u;
    word_t               hi_nxt;
    word_t               lo_nxt;
    logic                div_by_zero;

    // low 64 bits of a sign-extended product equal the signed product
    assign prod_s = {{WORD_W{op1[WORD_W-1]}}, op1} * {{WORD_W{op2[WORD_W-1]}}, op2};
    assign prod_u = {{WORD_W{1'b0}}, op1} * {{WORD_W{1'b0}}, op2};

    assign div_by_zero = (op2 == '0);
    assign divisor     = div_by_zero ? word_t'(1) : op2; // keeps the divider defined

    assign quot_s = $signed(op1) / $signed(divisor);
    assign rem_s  = $signed(op1) % $signed(divisor);
    assign quot_u = op1 / divisor;
    assign rem_u  = op1 % divisor;

    always_comb begin
        hi_nxt = hi;
        lo_nxt = lo;
        case (hilo_op)
            HILO_MULT: begin
                hi_nxt = prod_s[2*WORD_W-1:WORD_W];
                lo_nxt = prod_s[WORD_W-1:0];
            end
            HILO_MULTU: begin
                hi_nxt = prod_u[2*WORD_W-1:WORD_W];
                lo_nxt = prod_u[WORD_W-1:0];
            end
            HILO_DIV: begin
                hi_nxt = div_by_zero ? op1 : rem_s; // remainder in hi
                lo_nxt = div_by_zero ? HILO_DIV0_LO : quot_s;
            end
            HILO_DIVU: begin
                hi_nxt = div_by_zero ? op1 : rem_u;
                lo_nxt = div_by_zero ? HILO_DIV0_LO : quot_u;
            end
            HILO_MTHI: hi_nxt = op1;
            HILO_MTLO: lo_nxt = op1;
            default: ; // hold
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
            lo <= '0;
        end else begin
            hi <= hi_nxt;
            lo <= lo_nxt;
        end
    end

    // operand X on a hi/lo op would poison later mfhi/mflo
    hilo_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown({hi, lo})
    ) else $error("hilo: hi/lo went unknown");

endmodule

/* alu/mips_alu.sv */
`timescale 1ns/10ps

module mips_alu (
    input  mips_pkg::word_t   instr,
    input  mips_pkg::word_t   op1,
    input  mips_pkg::word_t   op2,
    input  mips_pkg::word_t   hi,
    input  mips_pkg::word_t   lo,
    input  mips_pkg::alu_op_e alu_op,
    input  logic              use_imm,
    input  logic              shift_by_reg,
    output mips_pkg::word_t   result,
    output mips_pkg::word_t   mem_addr,
    output logic              branch_taken
);
    import mips_pkg::*;

    logic [IMM_W-1:0] imm;
    word_t            sext_imm;
    word_t            zext_imm;
    word_t            operand_b;
    logic [4:0]       shamt;
    logic [4:0]       shift_amt;
    logic             signed_lt;
    logic             unsigned_lt;

    assign imm      = instr[15:0];
    assign sext_imm = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};
    assign zext_imm = {{(WORD_W-IMM_W){1'b0}}, imm};
    assign shamt    = instr[10:6];

    // second operand: rt data or the immediate
    always_comb begin
        if (!use_imm) begin
            operand_b = op2;
        end else if (alu_op inside {ALU_AND, ALU_OR, ALU_XOR}) begin
            operand_b = zext_imm; // andi, ori, xori
        end else begin
            operand_b = sext_imm;
        end
    end

    assign shift_amt   = shift_by_reg ? op1[4:0] : shamt; // only low 5 bits of rs
    assign signed_lt   = $signed(op1) < $signed(operand_b);
    assign unsigned_lt = op1 < operand_b; // sltiu compares the sign-extended imm

    assign mem_addr = op1 + sext_imm;

    always_comb begin
        result = '0;
        case (alu_op)
            ALU_ADD:     result = op1 + operand_b;
            ALU_SUB:     result = op1 - operand_b;
            ALU_AND:     result = op1 & operand_b;
            ALU_OR:      result = op1 | operand_b;
            ALU_XOR:     result = op1 ^ operand_b;
            ALU_NOR:     result = ~(op1 | operand_b);
            ALU_SLT:     result = {{(WORD_W-1){1'b0}}, signed_lt};
            ALU_SLTU:    result = {{(WORD_W-1){1'b0}}, unsigned_lt};
            ALU_SLL:     result = op2 << shift_amt;
            ALU_SRL:     result = op2 >> shift_amt;
            ALU_SRA:     result = $signed(op2) >>> shift_amt; // sign fill
            ALU_LUI:     result = {imm, {IMM_W{1'b0}}};
            ALU_PASS_HI: result = hi;
            ALU_PASS_LO: result = lo;
            default:     result = '0; // branch compares
        endcase
    end

    // branch compares, signed against zero or rs/rt equality
    always_comb begin
        case (alu_op)
            ALU_EQ:  branch_taken = (op1 == op2);
            ALU_NE:  branch_taken = (op1 != op2);
            ALU_LEZ: branch_taken = op1[WORD_W-1] || (op1 == '0);
            ALU_GTZ: branch_taken = !op1[WORD_W-1] && (op1 != '0);
            ALU_LTZ: branch_taken = op1[WORD_W-1];
            ALU_GEZ: branch_taken = !op1[WORD_W-1];
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* hdl/mips_decode.sv */
`timescale 1ns/10ps

module mips_decode (
    input  mips_pkg::word_t    instr,
    output mips_pkg::alu_op_e  alu_op,
    output mips_pkg::hilo_op_e hilo_op,
    output logic               use_imm,
    output logic               shift_by_reg,
    output mips_pkg::reg_idx_t dest_reg,
    output logic               wr_en,
    output logic               is_branch,
    output logic               is_mem,
    output logic               illegal
);
    import mips_pkg::*;

    opcode_e  opcode;
    funct_e   funct;
    regimm_e  rt_code;
    reg_idx_t rt;
    reg_idx_t rd;

    assign opcode  = opcode_e'(instr[31:26]);
    assign funct   = funct_e'(instr[5:0]);
    assign rt_code = regimm_e'(instr[20:16]);
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];

    assign dest_reg = (opcode == OP_SPECIAL) ? rd : rt; // r-type writes rd

    always_comb begin
        alu_op       = ALU_ADD;
        hilo_op      = HILO_NONE;
        use_imm      = 1'b0;
        shift_by_reg = 1'b0;
        wr_en        = 1'b0;
        is_branch    = 1'b0;
        is_mem       = 1'b0;
        illegal      = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                wr_en = 1'b1; // cleared below for hi/lo writers
                case (funct)
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    FN_SLLV: begin
                        alu_op       = ALU_SLL;
                        shift_by_reg = 1'b1;
                    end
                    FN_SRLV: begin
                        alu_op       = ALU_SRL;
                        shift_by_reg = 1'b1;
                    end
                    FN_SRAV: begin
                        alu_op       = ALU_SRA;
                        shift_by_reg = 1'b1;
                    end
                    FN_MFHI: alu_op = ALU_PASS_HI;
                    FN_MFLO: alu_op = ALU_PASS_LO;
                    FN_MTHI: begin
                        wr_en   = 1'b0;
                        hilo_op = HILO_MTHI;
                    end
                    FN_MTLO: begin
                        wr_en   = 1'b0;
                        hilo_op = HILO_MTLO;
                    end
                    FN_MULT: begin
                        wr_en   = 1'b0;
                        hilo_op = HILO_MULT;
                    end
                    FN_MULTU: begin
                        wr_en   = 1'b0;
                        hilo_op = HILO_MULTU;
                    end
                    FN_DIV: begin
                        wr_en   = 1'b0;
                        hilo_op = HILO_DIV;
                    end
                    FN_DIVU: begin
                        wr_en   = 1'b0;
                        hilo_op = HILO_DIVU;
                    end
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD; // no overflow trap
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: begin
                        wr_en   = 1'b0;
                        illegal = 1'b1;
                    end
                endcase
            end
            OP_REGIMM: begin
                is_branch = 1'b1; // link write is not handled here
                case (rt_code)
                    RI_BLTZ, RI_BLTZAL: alu_op = ALU_LTZ;
                    RI_BGEZ, RI_BGEZAL: alu_op = ALU_GEZ;
                    default: begin
                        is_branch = 1'b0;
                        illegal   = 1'b1;
                    end
                endcase
            end
            OP_BEQ: begin
                is_branch = 1'b1;
                alu_op    = ALU_EQ;
            end
            OP_BNE: begin
                is_branch = 1'b1;
                alu_op    = ALU_NE;
            end
            OP_BLEZ: begin
                is_branch = 1'b1;
                alu_op    = ALU_LEZ;
            end
            OP_BGTZ: begin
                is_branch = 1'b1;
                alu_op    = ALU_GTZ;
            end
            OP_ADDI, OP_ADDIU: begin
                alu_op  = ALU_ADD;
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OP_SLTI: begin
                alu_op  = ALU_SLT;
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OP_SLTIU: begin
                alu_op  = ALU_SLTU;
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OP_ANDI: begin
                alu_op  = ALU_AND;
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OP_ORI: begin
                alu_op  = ALU_OR;
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OP_XORI: begin
                alu_op  = ALU_XOR;
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OP_LUI: begin
                alu_op  = ALU_LUI;
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OP_LW, OP_SW: begin
                alu_op  = ALU_ADD; // address also on result
                use_imm = 1'b1;
                is_mem  = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* common/mips_pkg.sv */
package mips_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int IMM_W     = 16;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // lo value on division by zero
    localparam word_t HILO_DIV0_LO = 32'hFFFF_FFFF;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_REGIMM  = 6'd1,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_BLEZ    = 6'd6,
        OP_BGTZ    = 6'd7,
        OP_ADDI    = 6'd8,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL   = 6'd0,
        FN_SRL   = 6'd2,
        FN_SRA   = 6'd3,
        FN_SLLV  = 6'd4,
        FN_SRLV  = 6'd6,
        FN_SRAV  = 6'd7,
        FN_MFHI  = 6'd16,
        FN_MTHI  = 6'd17,
        FN_MFLO  = 6'd18,
        FN_MTLO  = 6'd19,
        FN_MULT  = 6'd24,
        FN_MULTU = 6'd25,
        FN_DIV   = 6'd26,
        FN_DIVU  = 6'd27,
        FN_ADD   = 6'd32,
        FN_ADDU  = 6'd33,
        FN_SUB   = 6'd34,
        FN_SUBU  = 6'd35,
        FN_AND   = 6'd36,
        FN_OR    = 6'd37,
        FN_XOR   = 6'd38,
        FN_NOR   = 6'd39,
        FN_SLT   = 6'd42,
        FN_SLTU  = 6'd43
    } funct_e;

    // rt field codes under OP_REGIMM
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'd0,
        RI_BGEZ   = 5'd1,
        RI_BLTZAL = 5'd16,
        RI_BGEZAL = 5'd17
    } regimm_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_PASS_HI, ALU_PASS_LO,
        ALU_EQ, ALU_NE, ALU_LEZ, ALU_GTZ, ALU_LTZ, ALU_GEZ
    } alu_op_e;

    typedef enum logic [2:0] {
        HILO_NONE, HILO_MULT, HILO_MULTU, HILO_DIV, HILO_DIVU, HILO_MTHI, HILO_MTLO
    } hilo_op_e;

endpackage
